//--- sim.f
src/flowPkg.sv
src/schedPkg.sv
src/flowScheduler.sv
src/flowMuxSelect.sv
src/flowFifo.sv
src/flowSteerTop.sv
sim/flowSteerTb.sv

//--- Makefile
# Verilator build and run of the flow steering testbench
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= flowSteerTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TEST FAILED

SOURCES := $(wildcard src/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Fails when the log holds the fail message or the simulator exits with an error
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/flowSteerTb.sv
// Flow steering testbench
// Random sources on four flows and a random sink drive the steering
// block through reset, mixed traffic, back-pressure, burst and idle
// flow phases. A scoreboard checks each output beat against the
// expected payload of its flow and sequence number.
`timescale 1ns/1ps

module flowSteerTb;

  import flowPkg::*;
  import schedPkg::*;

  localparam int DataWidth = 8;
  localparam int FifoDepth = 4;
  localparam int BurstLen  = 3;

  // Cycle budget per phase, stimulus plus drain
  localparam int PhaseCycles  = 400;
  localparam int ActiveCycles = 300;
  localparam int MaxCycles    = 4 * PhaseCycles + 200;

  // Source modes
  localparam int SrcOff    = 0;
  localparam int SrcRandom = 1;
  localparam int SrcAlways = 2;
  // Sink modes
  localparam int SinkHold   = 0;
  localparam int SinkRandom = 1;
  localparam int SinkOpen   = 2;

  logic                                clk      = 1'b0;
  logic                                rstN     = 1'b0;
  logic [FlowCount-1:0]                inValid  = '0;
  logic [FlowCount-1:0][DataWidth-1:0] inData   = '0;
  logic [FlowCount-1:0]                inReady;
  logic                                outReady = 1'b0;
  logic                                outValid;
  logic [DataWidth-1:0]                outData;
  flowIdT                              outFlow;

  // Phase control
  int                   seed      = 52857;
  int                   srcMode   = SrcOff;
  logic [FlowCount-1:0] srcMask   = '0;
  int                   sinkMode  = SinkOpen;
  logic                 runCheck  = 1'b0;
  logic                 onlyFlow2 = 1'b0;

  // Beats sent per flow, which is also the next source sequence number
  int srcSeq  [FlowCount] = '{default: 0};
  // Next expected sequence number per flow at the output
  int nextExp [FlowCount] = '{default: 0};
  int sentCount = 0;
  int outCount  = 0;

  // Burst run tracking and held beat memory
  int                   runLen   = 0;
  flowIdT               runFlow  = '0;
  logic                 prevHeld = 1'b0;
  logic [DataWidth-1:0] prevData = '0;
  flowIdT               prevFlow = '0;

  int cycle  = 0;
  int checks = 0;
  int errors = 0;

  always #50 clk = ~clk;

  flowSteerTop #(
    .DataWidth(DataWidth),
    .FifoDepth(FifoDepth),
    .BurstLen (BurstLen)
  ) i_dut (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inData   (inData),
    .inReady  (inReady),
    .outReady (outReady),
    .outValid (outValid),
    .outData  (outData),
    .outFlow  (outFlow)
  );

  // ------------------------------------------------------------------
  // Reference model and compare tasks
  // ------------------------------------------------------------------

  // Payload of beat n on flow f
  function automatic logic [DataWidth-1:0] expectedData(input int f, input int n);
    return DataWidth'((f * 64 + n) % 256);
  endfunction

  task automatic checkData(input string name, input logic [DataWidth-1:0] expected,
                           input logic [DataWidth-1:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic checkFlow(input string name, input flowIdT expected, input flowIdT actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic checkCount(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected)
    begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // ------------------------------------------------------------------
  // Sources and sink
  // ------------------------------------------------------------------

  always @(posedge clk)
  begin : driveFlows
    int   n;
    int   accepted;
    logic present;
    accepted = 0;
    if (rstN)
    begin
      for (int f = 0; f < FlowCount; f++)
      begin
        n = srcSeq[f];
        if (inValid[f] && inReady[f])
        begin
          n = n + 1;
          accepted = accepted + 1;
          srcSeq[f] <= n;
        end
        // Stalled beat keeps valid and data, otherwise pick the next one
        if (!inValid[f] || inReady[f])
        begin
          case (srcMode)
            SrcAlways: present = srcMask[f];
            SrcRandom: present = srcMask[f] && (($random(seed) & 1) != 0);
            default:   present = 1'b0;
          endcase
          inValid[f] <= present;
          inData[f]  <= expectedData(f, n);
        end
      end
      sentCount <= sentCount + accepted;
      case (sinkMode)
        SinkHold:   outReady <= 1'b0;
        SinkRandom: outReady <= (($random(seed) & 3) != 0);
        default:    outReady <= 1'b1;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Output scoreboard
  // ------------------------------------------------------------------

  always @(posedge clk)
  begin : compareOutputs
    int f;
    if (rstN)
    begin
      if ($countones(inReady) > 1)
      begin
        errors++;
        $display("ERROR: several inReady bits are high together in cycle %0d", cycle);
      end
      // Beat held by the sink must not change
      if (prevHeld)
      begin
        checkCount("held beat valid", 1, int'(outValid));
        checkData("held beat data", prevData, outData);
        checkFlow("held beat flow", prevFlow, outFlow);
      end
      prevHeld <= outValid && !outReady;
      prevData <= outData;
      prevFlow <= outFlow;
      if (outValid && outReady)
      begin
        f = int'(outFlow);
        checkData($sformatf("order flow %0d beat %0d", f, nextExp[f]),
                  expectedData(f, nextExp[f]), outData);
        nextExp[f] <= nextExp[f] + 1;
        outCount   <= outCount + 1;
        if (onlyFlow2)
        begin
          checkFlow("idle skip flow", 2'd2, outFlow);
        end
        if (runCheck)
        begin
          if (runLen == 0)
          begin
            runFlow <= outFlow;
            runLen  <= 1;
          end
          else if (outFlow == runFlow)
          begin
            if (runLen >= BurstLen)
            begin
              checkCount("burst run over limit", BurstLen, runLen + 1);
            end
            runLen <= runLen + 1;
          end
          else
          begin
            checkCount("burst run length", BurstLen, runLen);
            checkFlow("burst rotation", flowIdT'(runFlow + 1'b1), outFlow);
            runFlow <= outFlow;
            runLen  <= 1;
          end
        end
      end
      if (!runCheck)
      begin
        runLen <= 0;
      end
    end
  end

  // Hard stop
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= MaxCycles)
    begin
      errors++;
      $display("ERROR: timeout, the run did not finish within %0d cycles", MaxCycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Phase control
  // ------------------------------------------------------------------

  task automatic startPhase(input int src, input logic [FlowCount-1:0] mask, input int sink);
    srcMode  <= src;
    srcMask  <= mask;
    sinkMode <= sink;
  endtask

  // Stop new beats, open the sink and wait until everything has left
  task automatic drainFlows();
    srcMode  <= SrcOff;
    sinkMode <= SinkOpen;
    runCheck <= 1'b0;
    do
    begin
      @(posedge clk);
    end
    while ((inValid != '0) || outValid);
    repeat (2) @(posedge clk);
  endtask

  // Every beat sent on a flow has come out
  task automatic checkScoreboard(input string name);
    for (int f = 0; f < FlowCount; f++)
    begin
      checkCount($sformatf("%s beats out of flow %0d", name, f), srcSeq[f], nextExp[f]);
    end
  endtask

  initial
  begin : runPhases
    int         base;
    int         outBase;
    schedStateT stateSeen;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);

    // Idle after reset, no flow is valid so no flow sees ready
    stateSeen = i_dut.uScheduler.state;
    checkFlow("reset select", '0, i_dut.select);
    checkCount($sformatf("reset state %s", stateSeen.name()), int'(SchedScan),
               int'(stateSeen));
    repeat (4)
    begin
      checkCount("reset outValid", 0, int'(outValid));
      checkCount("idle inReady bits", 0, $countones(inReady));
      @(posedge clk);
    end

    // Mixed random traffic
    startPhase(SrcRandom, '1, SinkRandom);
    repeat (ActiveCycles) @(posedge clk);
    drainFlows();
    checkScoreboard("mixed");

    // Sink held off, only the FIFO depth gets in
    base = sentCount;
    startPhase(SrcRandom, '1, SinkHold);
    repeat (ActiveCycles) @(posedge clk);
    checkCount("back-pressure accepted beats", FifoDepth, sentCount - base);
    drainFlows();
    checkScoreboard("back-pressure");

    // All flows busy, open sink
    startPhase(SrcAlways, '1, SinkOpen);
    runCheck <= 1'b1;
    repeat (ActiveCycles) @(posedge clk);
    drainFlows();
    checkScoreboard("burst");

    // Only flow 2 ever valid
    base    = sentCount;
    outBase = outCount;
    startPhase(SrcRandom, 4'b0100, SinkRandom);
    onlyFlow2 <= 1'b1;
    repeat (ActiveCycles) @(posedge clk);
    drainFlows();
    onlyFlow2 <= 1'b0;
    checkCount("idle skip beat count", sentCount - base, outCount - outBase);
    checkScoreboard("idle skip");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : flowSteerTb

//--- src/flowSteerTop.sv
// Flow steering top level
// Merges the input flows into one tagged output flow. The
// scheduler picks a flow, the mux routes it and the FIFO
// buffers accepted beats under output back-pressure.
`timescale 1ns/1ps

module flowSteerTop #(
  parameter int DataWidth = flowPkg::DefaultDataWidth,
  parameter int FifoDepth = flowPkg::DefaultFifoDepth,
  parameter int BurstLen  = schedPkg::DefaultBurstLen
) (
  input  logic                                         clk,
  input  logic                                         rstN,
  // Input flows
  input  logic [flowPkg::FlowCount-1:0]                inValid,
  input  logic [flowPkg::FlowCount-1:0][DataWidth-1:0] inData,
  output logic [flowPkg::FlowCount-1:0]                inReady,
  // Merged output flow
  input  logic                                         outReady,
  output logic                                         outValid,
  output logic [DataWidth-1:0]                         outData,
  output flowPkg::flowIdT                              outFlow
);

  import flowPkg::*;

  flowIdT               select;
  logic                 muxValid;
  logic                 muxReady;
  logic [DataWidth-1:0] muxData;

  // ------------------------------------------------------------------
  // Producer, scheduler and mux
  // ------------------------------------------------------------------

  flowScheduler #(
    .BurstLen(BurstLen)
  ) uScheduler (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .muxValid (muxValid),
    .muxReady (muxReady),
    .select   (select)
  );

  flowMuxSelect #(
    .DataWidth(DataWidth)
  ) uMux (
    .clk      (clk),
    .rstN     (rstN),
    .select   (select),
    .inValid  (inValid),
    .inData   (inData),
    .inReady  (inReady),
    .muxReady (muxReady),
    .muxValid (muxValid),
    .muxData  (muxData)
  );

  // Buffer, tagged with the select that routed each beat
  flowFifo #(
    .DataWidth(DataWidth),
    .FifoDepth(FifoDepth)
  ) uFifo (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (muxValid),
    .pushData  (muxData),
    .pushFlow  (select),
    .pushReady (muxReady),
    .popReady  (outReady),
    .popValid  (outValid),
    .popData   (outData),
    .popFlow   (outFlow)
  );

endmodule : flowSteerTop

//--- src/flowFifo.sv
// Tagged flow FIFO
// Circular buffer between the flow mux and the output. Each
// accepted beat is stored with its flow number and the oldest
// entry is presented on the pop side. One cycle from push into
// an empty buffer to popValid.
`timescale 1ns/1ps

module flowFifo #(
  parameter int DataWidth = flowPkg::DefaultDataWidth,
  // Power of two, at least 2
  parameter int FifoDepth = flowPkg::DefaultFifoDepth
) (
  input  logic                 clk,
  input  logic                 rstN,
  // Push side, from the mux
  input  logic                 pushValid,
  input  logic [DataWidth-1:0] pushData,
  input  flowPkg::flowIdT      pushFlow,
  output logic                 pushReady,
  // Pop side, to the outside
  input  logic                 popReady,
  output logic                 popValid,
  output logic [DataWidth-1:0] popData,
  output flowPkg::flowIdT      popFlow
);

  import flowPkg::*;

  localparam int AddrWidth = $clog2(FifoDepth);

  // Storage, payload and tag side by side
  logic [DataWidth-1:0] dataMem [FifoDepth];
  flowIdT               flowMem [FifoDepth];

  // Extra MSB tells full from empty
  logic [AddrWidth:0]   wrPtr;
  logic [AddrWidth:0]   rdPtr;
  logic                 empty;
  logic                 full;
  logic                 doPush;
  logic                 doPop;

  // ------------------------------------------------------------------
  // Status and handshake
  // ------------------------------------------------------------------

  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[AddrWidth] != rdPtr[AddrWidth]) &&
                 (wrPtr[AddrWidth-1:0] == rdPtr[AddrWidth-1:0]);

  // A full buffer still takes a beat when one leaves in the same cycle
  assign pushReady = !full || popReady;
  assign popValid  = !empty;

  assign doPush = pushValid && pushReady;
  assign doPop  = popValid && popReady;

  // Oldest entry
  assign popData = dataMem[rdPtr[AddrWidth-1:0]];
  assign popFlow = flowMem[rdPtr[AddrWidth-1:0]];

  // ------------------------------------------------------------------
  // Pointers and storage
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (doPush)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      dataMem[wrPtr[AddrWidth-1:0]] <= pushData;
      flowMem[wrPtr[AddrWidth-1:0]] <= pushFlow;
    end
  end

  // Write into a full buffer only alongside a read
  assert property (@(posedge clk) disable iff (!rstN)
    (doPush && full) |-> doPop);

  // Held output beat keeps its payload and tag
  assert property (@(posedge clk) disable iff (!rstN)
    (popValid && !popReady) |=> ($stable(popData) && $stable(popFlow)));

endmodule : flowFifo

//--- src/flowMuxSelect.sv
// Flow mux with explicit select
// Purely combinational ready-valid mux. The selected flow's valid
// and data go to the pop side and the pop ready returns only to
// the selected flow. Zero cycles from select or inputs to outputs.
`timescale 1ns/1ps

module flowMuxSelect #(
  // Must be at least 1
  parameter int DataWidth = flowPkg::DefaultDataWidth
) (
  // Clock and reset serve the checks only
  input  logic                                         clk,
  input  logic                                         rstN,
  input  flowPkg::flowIdT                              select,
  input  logic [flowPkg::FlowCount-1:0]                inValid,
  input  logic [flowPkg::FlowCount-1:0][DataWidth-1:0] inData,
  output logic [flowPkg::FlowCount-1:0]                inReady,
  input  logic                                         muxReady,
  output logic                                         muxValid,
  output logic [DataWidth-1:0]                         muxData
);

  import flowPkg::*;

  // ------------------------------------------------------------------
  // Integration checks
  // ------------------------------------------------------------------

  // Select must address an existing flow
  assert property (@(posedge clk) disable iff (!rstN)
    select < FlowCount);

  // Stalled selected flow pins the select,
  // otherwise muxValid could drop without a transfer
  assert property (@(posedge clk) disable iff (!rstN)
    (inValid[select] && !inReady[select]) |=> $stable(select));

  // ------------------------------------------------------------------
  // Routing
  // ------------------------------------------------------------------

  // One-hot ready, only the selected flow sees it and only while valid
  assign inReady  = FlowCount'(muxReady && muxValid) << select;

  // Forward path of the selected flow
  assign muxValid = inValid[select];
  assign muxData  = inData[select];

endmodule : flowMuxSelect

//--- src/flowScheduler.sv
// Rotating burst scheduler
// Drives the explicit select of the flow mux. A flow keeps the
// grant for up to BurstLen accepted beats. The grant moves to the
// next flow in order once the burst is used up or the selected
// flow shows no valid, and never while the selected flow stalls.
`timescale 1ns/1ps

module flowScheduler #(
  // Must be at least 1
  parameter int BurstLen = schedPkg::DefaultBurstLen
) (
  input  logic                          clk,
  // Synchronous, active low
  input  logic                          rstN,
  input  logic [flowPkg::FlowCount-1:0] inValid,
  // Pop side handshake of the mux
  input  logic                          muxValid,
  input  logic                          muxReady,
  output flowPkg::flowIdT               select
);

  import schedPkg::*;

  // Wide enough to hold BurstLen itself
  localparam int CountWidth = $clog2(BurstLen + 1);
  localparam logic [CountWidth-1:0] LastCount = CountWidth'(BurstLen - 1);

  schedStateT            state;
  logic [CountWidth-1:0] beatCount;
  logic                  selValid;
  logic                  beatDone;
  logic                  lastBeat;
  logic                  moveOn;

  // ------------------------------------------------------------------
  // Grant decision
  // ------------------------------------------------------------------

  assign selValid = inValid[select];
  // Beat accepted by the FIFO this cycle
  assign beatDone = muxValid && muxReady;
  // Final beat of the grant
  assign lastBeat = beatDone && (beatCount == LastCount);
  // Idle flow or spent burst, a stalled flow holds the grant
  assign moveOn   = !selValid || lastBeat;

  // ------------------------------------------------------------------
  // State, select and beat counter
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state     <= SchedScan;
      select    <= '0;
      beatCount <= '0;
    end
    else
    begin
      case (state)
        SchedScan:
        begin
          if (moveOn)
          begin
            // Wraps from 3 back to 0
            select <= select + 1'b1;
          end
          else
          begin
            state <= SchedBurst;
            if (beatDone)
            begin
              beatCount <= beatCount + 1'b1;
            end
          end
        end
        SchedBurst:
        begin
          if (moveOn)
          begin
            state     <= SchedScan;
            select    <= select + 1'b1;
            beatCount <= '0;
          end
          else if (beatDone)
          begin
            beatCount <= beatCount + 1'b1;
          end
        end
        default:
        begin
          state     <= SchedScan;
          beatCount <= '0;
        end
      endcase
    end
  end

  // Counter is cleared on the last beat, so BurstLen is never held
  assert property (@(posedge clk) disable iff (!rstN)
    beatCount < CountWidth'(BurstLen));

endmodule : flowScheduler

//--- src/schedPkg.sv
// Scheduler control package
// State encoding and default grant size for the rotating
// burst scheduler
package schedPkg;

  // ------------------------------------------------------------------
  // Scheduler states
  // ------------------------------------------------------------------

  // SchedScan looks for a valid flow
  // SchedBurst holds the current flow for its burst
  typedef enum logic
  {
    SchedScan  = 1'b0,
    SchedBurst = 1'b1
  } schedStateT;

  // Max accepted beats per grant before moving on
  localparam int DefaultBurstLen = 3;

endpackage : schedPkg

//--- src/flowPkg.sv
// Flow format package
// Shared description of the steered flows: how many there are,
// the flow number carried as select and tag, and the default
// payload width and buffer depth used by the top level
package flowPkg;

  // ------------------------------------------------------------------
  // Flow count and flow number
  // ------------------------------------------------------------------

  // Number of input flows merged by the steering block
  localparam int FlowCount = 4;

  // Flow number, used as mux select and as FIFO and output tag
  typedef logic [1:0] flowIdT;

  // ------------------------------------------------------------------
  // Default sizes
  // ------------------------------------------------------------------

  // Payload width of one beat
  localparam int DefaultDataWidth = 8;

  // Entries in the output buffer, power of two
  localparam int DefaultFifoDepth = 4;

endpackage : flowPkg
